// File: files.f
+incdir+logic
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/wb_if.sv
logic/inval_sequencer.sv
logic/cache_slice.sv
logic/mem_controller.sv
logic/cache_mem_top.sv
test/cache_mem_sva.sv
test/cache_mem_checker.sv
test/cache_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cache memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module cache_mem_tb -o cache_mem_sim \
  && { ./obj_dir/cache_mem_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } \
  && ! grep -q "RESULT: FAIL" sim.log \
  && grep -q "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: test/cache_mem_tb.sv
`timescale 1ns/1ns
`include "mem_defs.svh"

module cache_mem_tb;

  localparam int TOTAL_OPS = 12 + 5 + 10 + `HOST_PORTS * 24 + 4;
  localparam int LIMIT = TOTAL_OPS * `HOST_PORTS * (`MEM_LATENCY + 2) + 2 * 16 + 3 + 100;

  logic clk;
  logic rst_async;
  logic flush;
  logic [`HOST_PORTS-1:0]            host_cyc;
  logic [`HOST_PORTS-1:0]            host_stb;
  logic [`HOST_PORTS-1:0]            host_we;
  bus_pkg::sel_t [`HOST_PORTS-1:0]   host_sel;
  bus_pkg::addr_t [`HOST_PORTS-1:0]  host_adr;
  bus_pkg::word_t [`HOST_PORTS-1:0]  host_dat_w;
  bus_pkg::word_t [`HOST_PORTS-1:0]  host_dat_r;
  logic [`HOST_PORTS-1:0]            host_ack;
  logic                              ready;
  int                                test_id;
  int                                tb_errors;
  logic [31:0]                       lfsr;

  cache_mem_top UUT (.*);

  cache_mem_checker u_check (.*);

  bind cache_mem_top cache_mem_sva u_sva (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // one classic cycle between falling edges
  task automatic wb_cycle(int p, logic we, bus_pkg::sel_t sel, bus_pkg::addr_t adr,
                          bus_pkg::word_t dat);
    while (!ready) @(negedge clk);
    host_we[p]    = we;
    host_sel[p]   = sel;
    host_adr[p]   = adr;
    host_dat_w[p] = dat;
    host_cyc[p]   = 1'b1;
    host_stb[p]   = 1'b1;
    do @(negedge clk); while (!host_ack[p]);
    // the ack completes at the next rising edge
    @(negedge clk);
    host_cyc[p] = 1'b0;
    host_stb[p] = 1'b0;
    @(negedge clk);
  endtask

  task automatic count_sweep(string name);
    int n;
    n = 0;
    while (!ready) begin
      if (host_ack != '0) begin
        $display("%s: host ack seen during invalidation sweep", name);
        tb_errors++;
      end
      n++;
      @(negedge clk);
    end
    if (n != 16) begin
      $display("[FAIL] %s ready low cycles: expected 16 actual %0d", name, n);
      tb_errors++;
    end
  endtask

  task automatic run_random(int p);
    bus_pkg::addr_t q[$];
    bus_pkg::addr_t a;
    int k;
    for (int j = 0; j < 4; j++) begin
      a = {2'(p), 6'(rand_bits(6))};
      wb_cycle(p, 1'b1, 4'hf, a, rand_bits(32));
      q.push_back(a);
    end
    for (int j = 0; j < 20; j++) begin
      k = int'(rand_bits(2)) % q.size();
      if (rand_bits(1)) wb_cycle(p, 1'b1, 4'(rand_bits(4)), q[k], rand_bits(32));
      else              wb_cycle(p, 1'b0, 4'hf, q[k], '0);
    end
  endtask

  initial begin
    lfsr = 32'hebee;
    tb_errors = 0;
    test_id = 0;
    rst_async = 1'b1;
    flush = 1'b0;
    host_cyc = '0;
    host_stb = '0;
    host_we = '0;
    host_sel = '0;
    host_adr = '0;
    host_dat_w = '0;
    repeat (3) @(negedge clk);
    rst_async = 1'b0;
    count_sweep("reset");

    test_id = 1;
    for (int i = 0; i < 4; i++) begin
      wb_cycle(0, 1'b1, 4'hf, 8'(i * 3 + 1), rand_bits(32));
      wb_cycle(0, 1'b1, 4'(rand_bits(4)), 8'(i * 3 + 1), rand_bits(32));
      wb_cycle(0, 1'b0, 4'hf, 8'(i * 3 + 1), '0);
    end

    test_id = 2;
    wb_cycle(0, 1'b1, 4'hf, 8'h2a, rand_bits(32));
    repeat (4) wb_cycle(0, 1'b0, 4'hf, 8'h2a, '0);

    // same index with different tags
    test_id = 3;
    wb_cycle(0, 1'b1, 4'hf, 8'h06, rand_bits(32));
    wb_cycle(0, 1'b1, 4'hf, 8'h36, rand_bits(32));
    repeat (4) begin
      wb_cycle(0, 1'b0, 4'hf, 8'h06, '0);
      wb_cycle(0, 1'b0, 4'hf, 8'h36, '0);
    end

    test_id = 4;
    fork
      run_random(0);
      run_random(1);
      run_random(2);
      run_random(3);
    join

    test_id = 5;
    wb_cycle(1, 1'b1, 4'hf, 8'h45, rand_bits(32));
    wb_cycle(1, 1'b0, 4'hf, 8'h45, '0);
    wb_cycle(1, 1'b0, 4'hf, 8'h45, '0);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    count_sweep("flush");
    wb_cycle(1, 1'b0, 4'hf, 8'h45, '0);

    repeat (2) @(negedge clk);
    $display("summary: checks=%0d checker_errors=%0d tb_errors=%0d assertion_errors=%0d",
             u_check.check_count, u_check.error_count, tb_errors, UUT.u_sva.fail_count);
    if (u_check.error_count + tb_errors + UUT.u_sva.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: test/cache_mem_checker.sv
`timescale 1ns/1ns
`include "mem_defs.svh"

module cache_mem_checker (
  input logic                                clk,
  input logic                                rst_async,
  input logic                                ready,
  input logic [`HOST_PORTS-1:0]              host_cyc,
  input logic [`HOST_PORTS-1:0]              host_stb,
  input logic [`HOST_PORTS-1:0]              host_we,
  input logic [`HOST_PORTS-1:0]              host_ack,
  input bus_pkg::sel_t [`HOST_PORTS-1:0]     host_sel,
  input bus_pkg::addr_t [`HOST_PORTS-1:0]    host_adr,
  input bus_pkg::word_t [`HOST_PORTS-1:0]    host_dat_w,
  input bus_pkg::word_t [`HOST_PORTS-1:0]    host_dat_r,
  input int                                  test_id
);

  localparam int LINES = 1 << `INDEX_BITS;

  int error_count = 0;
  int check_count = 0;

  bus_pkg::word_t  model [1 << `MEM_ADDR_BITS];
  logic            written [1 << `MEM_ADDR_BITS];
  // expected line state of each slice, for hit prediction
  logic            line_valid [`HOST_PORTS][LINES];
  logic [`MEM_ADDR_BITS-`INDEX_BITS-1:0] line_tag [`HOST_PORTS][LINES];
  int              wait_cycles [`HOST_PORTS];
  logic            predict_hit [`HOST_PORTS];

  function automatic bus_pkg::word_t merge_expected(bus_pkg::word_t old_w,
                                                    bus_pkg::word_t new_w,
                                                    bus_pkg::sel_t sel);
    bus_pkg::word_t result;
    for (int b = 0; b < 4; b++) begin
      result[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return result;
  endfunction

  function automatic string test_name(int id);
    case (id)
      1:       return "write_read";
      2:       return "hit_repeat";
      3:       return "conflict";
      4:       return "random_ports";
      5:       return "flush";
      default: return "reset";
    endcase
  endfunction

  initial begin
    for (int a = 0; a < (1 << `MEM_ADDR_BITS); a++) written[a] = 1'b0;
  end

  always @(posedge clk) begin : watch
    bus_pkg::addr_t a;
    int idx;
    if (!rst_async) begin
      // a sweep empties every slice
      if (!ready) begin
        for (int p = 0; p < `HOST_PORTS; p++) begin
          for (int l = 0; l < LINES; l++) line_valid[p][l] = 1'b0;
          wait_cycles[p] = 0;
        end
      end
      for (int p = 0; p < `HOST_PORTS; p++) begin
        a   = host_adr[p];
        idx = int'(a[`INDEX_BITS-1:0]);
        if (host_cyc[p] && host_stb[p] && !host_ack[p]) begin
          if (wait_cycles[p] == 0) begin
            predict_hit[p] = line_valid[p][idx] &&
                             line_tag[p][idx] == a[`MEM_ADDR_BITS-1:`INDEX_BITS];
          end
          wait_cycles[p]++;
        end else if (host_cyc[p] && host_stb[p] && host_ack[p]) begin
          check_count++;
          if (host_we[p]) begin
            model[a]   = merge_expected(model[a], host_dat_w[p], host_sel[p]);
            written[a] = 1'b1;
          end else begin
            if (!written[a]) begin
              $display("%s: port %0d read address %0h that was never written",
                       test_name(test_id), p, a);
              error_count++;
            end else if (host_dat_r[p] !== model[a]) begin
              $display("[FAIL] %s port %0d adr %0h: expected %h actual %h",
                       test_name(test_id), p, a, model[a], host_dat_r[p]);
              error_count++;
            end
            if (predict_hit[p] && wait_cycles[p] != 1) begin
              $display("[FAIL] %s port %0d hit latency: expected 1 actual %0d",
                       test_name(test_id), p, wait_cycles[p]);
              error_count++;
            end else if (!predict_hit[p] && wait_cycles[p] == 1) begin
              $display("[FAIL] %s port %0d miss latency: expected >1 actual 1",
                       test_name(test_id), p);
              error_count++;
            end
            line_valid[p][idx] = 1'b1;
            line_tag[p][idx]   = a[`MEM_ADDR_BITS-1:`INDEX_BITS];
          end
          wait_cycles[p] = 0;
        end
      end
    end
  end

endmodule

// File: test/cache_mem_sva.sv
`timescale 1ns/1ns
`include "mem_defs.svh"

module cache_mem_sva (
  input logic                    clk,
  input logic                    rst_async,
  input logic [`HOST_PORTS-1:0]  host_cyc,
  input logic [`HOST_PORTS-1:0]  host_stb,
  input logic [`HOST_PORTS-1:0]  host_ack,
  input logic                    ready
);

  int fail_count = 0;

  for (genvar i = 0; i < `HOST_PORTS; i++) begin : g_rules
    // ack only answers an open cycle
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst_async)
      host_ack[i] |-> (host_cyc[i] && host_stb[i]))
      else begin
        $error("port %0d ack without cyc and stb", i);
        fail_count++;
      end

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst_async)
      host_ack[i] |=> !host_ack[i])
      else begin
        $error("port %0d ack held two cycles", i);
        fail_count++;
      end

    a_ack_when_ready: assert property (@(posedge clk) disable iff (rst_async)
      host_ack[i] |-> ready)
      else begin
        $error("port %0d ack while invalidating", i);
        fail_count++;
      end
  end

endmodule

// File: logic/cache_mem_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module cache_mem_top (
  input  logic                                clk,
  input  logic                                rst_async,
  input  logic                                flush,
  input  logic [`HOST_PORTS-1:0]              host_cyc,
  input  logic [`HOST_PORTS-1:0]              host_stb,
  input  logic [`HOST_PORTS-1:0]              host_we,
  input  bus_pkg::sel_t [`HOST_PORTS-1:0]     host_sel,
  input  bus_pkg::addr_t [`HOST_PORTS-1:0]    host_adr,
  input  bus_pkg::word_t [`HOST_PORTS-1:0]    host_dat_w,
  output bus_pkg::word_t [`HOST_PORTS-1:0]    host_dat_r,
  output logic [`HOST_PORTS-1:0]              host_ack,
  output logic                                ready
);

  logic               inval_valid;
  cache_pkg::index_t  inval_index;

  wb_if mem_bus [`HOST_PORTS] ();

  inval_sequencer u_inval (
    .clk         (clk),
    .rst_async   (rst_async),
    .flush       (flush),
    .inval_valid (inval_valid),
    .inval_index (inval_index),
    .ready       (ready)
  );

  for (genvar p = 0; p < `HOST_PORTS; p++) begin : g_slice
    cache_slice u_slice (
      .clk         (clk),
      .rst_async   (rst_async),
      .host_cyc    (host_cyc[p]),
      .host_stb    (host_stb[p]),
      .host_we     (host_we[p]),
      .host_sel    (host_sel[p]),
      .host_adr    (host_adr[p]),
      .host_dat_w  (host_dat_w[p]),
      .host_dat_r  (host_dat_r[p]),
      .host_ack    (host_ack[p]),
      .inval_valid (inval_valid),
      .inval_index (inval_index),
      .mem         (mem_bus[p])
    );
  end

  mem_controller u_mem (
    .clk       (clk),
    .rst_async (rst_async),
    .slv       (mem_bus)
  );

endmodule

`default_nettype wire

// File: logic/mem_controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module mem_controller (
  input  logic  clk,
  input  logic  rst_async,
  wb_if.slave   slv [`HOST_PORTS]
);

  localparam int PW    = $clog2(`HOST_PORTS);
  localparam int CW    = $clog2(`MEM_LATENCY + 1);
  localparam int WORDS = 1 << `MEM_ADDR_BITS;
  localparam logic [CW-1:0] CNT_LAST = CW'(`MEM_LATENCY - 1);

  typedef logic [PW-1:0] port_t;

  bus_pkg::mem_state_e  state;
  port_t                grant;
  port_t                pick;
  logic                 found;
  logic [CW-1:0]        cnt;

  logic [`HOST_PORTS-1:0]  req_v;
  logic [`HOST_PORTS-1:0]  we_v;
  bus_pkg::sel_t           sel_v [`HOST_PORTS];
  bus_pkg::addr_t          adr_v [`HOST_PORTS];
  bus_pkg::word_t          dat_v [`HOST_PORTS];

  bus_pkg::word_t          mem_q [WORDS];
  bus_pkg::word_t          rdata;

  for (genvar i = 0; i < `HOST_PORTS; i++) begin : g_port
    logic granted;
    assign granted      = (state == bus_pkg::mem_ack) && (grant == port_t'(i));
    assign req_v[i]     = slv[i].cyc && slv[i].stb;
    assign we_v[i]      = slv[i].we;
    assign sel_v[i]     = slv[i].sel;
    assign adr_v[i]     = slv[i].adr;
    assign dat_v[i]     = slv[i].dat_w;
    assign slv[i].ack   = granted;
    assign slv[i].dat_r = granted ? rdata : '0;
  end

  // round robin from the port after the last grant;
  // the port being acked still holds cyc, so skip it
  always_comb begin
    port_t idx;
    pick  = grant;
    found = 1'b0;
    for (int k = 1; k <= `HOST_PORTS; k++) begin
      idx = port_t'((int'(grant) + k) % `HOST_PORTS);
      if (!found && req_v[idx] && !(state == bus_pkg::mem_ack && idx == grant)) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst_async) begin
    if (rst_async) begin
      state <= bus_pkg::mem_idle;
      grant <= port_t'(`HOST_PORTS - 1);
      cnt   <= '0;
    end else begin
      case (state)
        bus_pkg::mem_busy: begin
          if (cnt == CNT_LAST) state <= bus_pkg::mem_ack;
          else                 cnt   <= cnt + 1'b1;
        end
        default: begin
          // idle or ack, next grant goes straight to busy
          if (found) begin
            grant <= pick;
            cnt   <= '0;
            state <= bus_pkg::mem_busy;
          end else begin
            state <= bus_pkg::mem_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == bus_pkg::mem_busy && cnt == CNT_LAST) rdata <= mem_q[adr_v[grant]];
    if (state == bus_pkg::mem_ack && we_v[grant]) begin
      mem_q[adr_v[grant]] <= bus_pkg::merge_bytes(mem_q[adr_v[grant]], dat_v[grant],
                                                  sel_v[grant]);
    end
  end

endmodule

`default_nettype wire

// File: logic/cache_slice.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module cache_slice (
  input  logic                 clk,
  input  logic                 rst_async,
  input  logic                 host_cyc,
  input  logic                 host_stb,
  input  logic                 host_we,
  input  bus_pkg::sel_t        host_sel,
  input  bus_pkg::addr_t       host_adr,
  input  bus_pkg::word_t       host_dat_w,
  output bus_pkg::word_t       host_dat_r,
  output logic                 host_ack,
  input  logic                 inval_valid,
  input  cache_pkg::index_t    inval_index,
  wb_if.master                 mem
);

  localparam int LINES = 1 << `INDEX_BITS;

  cache_pkg::line_t         lines [LINES];
  cache_pkg::slice_state_e  state;

  // request held while the memory cycle runs
  bus_pkg::addr_t           req_adr;
  bus_pkg::word_t           req_dat;
  bus_pkg::sel_t            req_sel;
  bus_pkg::word_t           rdata;

  cache_pkg::index_t        host_index;
  cache_pkg::tag_t          host_tag;
  cache_pkg::line_t         host_line;
  logic                     host_hit;
  cache_pkg::index_t        req_index;
  cache_pkg::tag_t          req_tag;
  cache_pkg::line_t         req_line;
  logic                     req_hit;
  cache_pkg::line_t         new_line;
  logic                     line_we;
  logic                     take;
  logic                     mem_busy;

  assign host_index = host_adr[`INDEX_BITS-1:0];
  assign host_tag   = host_adr[`MEM_ADDR_BITS-1:`INDEX_BITS];
  assign host_line  = lines[host_index];
  assign host_hit   = host_line.valid && (host_line.tag == host_tag);

  assign req_index  = req_adr[`INDEX_BITS-1:0];
  assign req_tag    = req_adr[`MEM_ADDR_BITS-1:`INDEX_BITS];
  assign req_line   = lines[req_index];
  assign req_hit    = req_line.valid && (req_line.tag == req_tag);

  // no new request during a sweep
  assign take = host_cyc && host_stb && !inval_valid;

  always_ff @(posedge clk or posedge rst_async) begin
    if (rst_async) begin
      state <= cache_pkg::slc_idle;
    end else begin
      case (state)
        cache_pkg::slc_idle: begin
          if (take) begin
            if (host_we)       state <= cache_pkg::slc_write;
            else if (host_hit) state <= cache_pkg::slc_respond;
            else               state <= cache_pkg::slc_fill;
          end
        end
        cache_pkg::slc_fill,
        cache_pkg::slc_write: begin
          if (mem.ack) state <= cache_pkg::slc_respond;
        end
        default: state <= cache_pkg::slc_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cache_pkg::slc_idle && take) begin
      req_adr <= host_adr;
      req_dat <= host_dat_w;
      req_sel <= host_sel;
    end
  end

  // hit data at accept, a miss overwrites it with the fill word
  always_ff @(posedge clk) begin
    if (state == cache_pkg::slc_idle && take && !host_we) begin
      rdata <= host_line.data;
    end else if (state == cache_pkg::slc_fill && mem.ack) begin
      rdata <= mem.dat_r;
    end
  end

  // fill on read miss, byte merge only when a write hits
  assign new_line = '{valid: 1'b1,
                      tag:   req_tag,
                      data:  (state == cache_pkg::slc_fill) ? mem.dat_r :
                             bus_pkg::merge_bytes(req_line.data, req_dat, req_sel)};
  assign line_we  = mem.ack && ((state == cache_pkg::slc_fill) ||
                                (state == cache_pkg::slc_write && req_hit));

  always_ff @(posedge clk) begin
    if (line_we) lines[req_index] <= new_line;
    // invalidation wins on the same index
    if (inval_valid) lines[inval_index].valid <= 1'b0;
  end

  assign mem_busy  = (state == cache_pkg::slc_fill) || (state == cache_pkg::slc_write);
  assign mem.cyc   = mem_busy;
  assign mem.stb   = mem_busy;
  assign mem.we    = (state == cache_pkg::slc_write);
  assign mem.sel   = req_sel;
  assign mem.adr   = req_adr;
  assign mem.dat_w = req_dat;

  assign host_ack   = (state == cache_pkg::slc_respond);
  assign host_dat_r = rdata;

endmodule

`default_nettype wire

// File: logic/inval_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module inval_sequencer (
  input  logic               clk,
  input  logic               rst_async,
  input  logic               flush,
  output logic               inval_valid,
  output cache_pkg::index_t  inval_index,
  output logic               ready
);

  logic               sweeping;
  cache_pkg::index_t  index_q;

  // one full sweep out of reset, another per flush
  always_ff @(posedge clk or posedge rst_async) begin
    if (rst_async) begin
      sweeping <= 1'b1;
      index_q  <= '0;
    end else if (sweeping) begin
      index_q <= index_q + 1'b1;
      // last index, counter wraps back to 0
      if (index_q == '1) sweeping <= 1'b0;
    end else if (flush) begin
      sweeping <= 1'b1;
      index_q  <= '0;
    end
  end

  assign inval_valid = sweeping;
  assign inval_index = index_q;
  assign ready       = !sweeping;

endmodule

`default_nettype wire

// File: logic/wb_if.sv
`timescale 1ns/1ns
`default_nettype none

// wishbone classic, one per slice on the memory side
interface wb_if;

  logic            cyc;
  logic            stb;
  logic            we;
  bus_pkg::sel_t   sel;
  bus_pkg::addr_t  adr;
  bus_pkg::word_t  dat_w;
  bus_pkg::word_t  dat_r;
  logic            ack;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// File: logic/cache_pkg.sv
`include "mem_defs.svh"

package cache_pkg;

  typedef logic [`INDEX_BITS-1:0]                  index_t;
  typedef logic [`MEM_ADDR_BITS-`INDEX_BITS-1:0]   tag_t;

  typedef struct packed {
    logic            valid;
    tag_t            tag;
    bus_pkg::word_t  data;
  } line_t;

  // slc_respond is the single host ack cycle
  typedef enum logic [1:0] {
    slc_idle,
    slc_respond,
    slc_fill,
    slc_write
  } slice_state_e;

endpackage

// File: logic/bus_pkg.sv
`include "mem_defs.svh"

package bus_pkg;

  typedef logic [31:0]                 word_t;
  typedef logic [`MEM_ADDR_BITS-1:0]   addr_t;
  typedef logic [3:0]                  sel_t;

  typedef enum logic [1:0] {mem_idle, mem_busy, mem_ack} mem_state_e;

  // byte lanes of new_word replace old_word where sel is set
  function automatic word_t merge_bytes(word_t old_word, word_t new_word, sel_t sel);
    word_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

// File: logic/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// host ports, one cache slice each
`define HOST_PORTS 4

// shared memory is word addressed
`define MEM_ADDR_BITS 8

// 16 lines per slice
`define INDEX_BITS 4

// grant to memory ack
`define MEM_LATENCY 2

`endif
